// ==== common/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// wait cycles of main memory before a word comes back
`define MEM_WAIT 2

// words per cache block, power of two
`define BLOCK_WORDS 4

// number of cache lines, power of two
`define CACHE_LINES 16

// size of main memory in 32-bit words
`define MEM_WORDS 1024

// all widths of index, offset and tag derive from these
// via $clog2 inside the modules that need them

`endif

// ==== common/cachePkg.sv ====
package cachePkg;

  // processor request
  // addr is a byte address, low two bits ignored
  // re and we are never set together
  typedef struct packed {
    logic        re;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } cpuReq;

  // request from the cache controller to main memory
  // same layout as the processor side
  // held stable until the memory answers with valid
  typedef struct packed {
    logic        re;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } memReq;

  // main memory sequencing
  // idle -> requested on a strobe
  // requested while the wait counter runs
  // retrieved for exactly one cycle, valid high there
  typedef enum logic [1:0] {
    memIdle,
    memRequested,
    memRetrieved
  } memState;

  // cache controller sequencing
  // fill walks a whole block on a read miss
  // write does one write-through access
  typedef enum logic [1:0] {
    ctrlIdle,
    ctrlFill,
    ctrlWrite
  } ctrlState;

endpackage

// ==== memory/slowMemory.sv ====
`include "cache_settings.svh"

module slowMemory #(
  parameter int waitCycles = 1
) (
  input  logic            clk,
  input  logic            rst,
  input  cachePkg::memReq req,
  output logic [31:0]     rdata,
  output logic            valid
);
  import cachePkg::*;

  // counter must reach waitCycles+1 to leave memRequested
  localparam int countBits = $clog2(waitCycles + 2);
  localparam logic [countBits-1:0] waitLimit = countBits'(waitCycles);
  localparam int addrBits = $clog2(`MEM_WORDS);

  memState state;
  memState nextState;
  logic [countBits-1:0] count;
  logic [31:0] words [`MEM_WORDS];
  logic [addrBits-1:0] wordAddr;

  // word address, byte offset dropped
  assign wordAddr = req.addr[addrBits+1:2];

  // state register
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= memIdle;
    else
      state <= nextState;
  end

  // next state
  always_comb
  begin
    nextState = state;
    case (state)
      memIdle:
        if (req.re || req.we)
          nextState = memRequested;
      memRequested:
        if (count > waitLimit)
          nextState = memRetrieved;
      memRetrieved:
        nextState = memIdle;
      default:
        nextState = memIdle;
    endcase
  end

  // wait counter, only runs while requested
  always_ff @(posedge clk)
  begin
    if (rst || state != memRequested)
      count <= '0;
    else
      count <= count + 1'b1;
  end

  // one-cycle answer pulse
  assign valid = (state == memRetrieved);

  // memory starts out all zero in simulation
  initial
  begin
    for (int i = 0; i < `MEM_WORDS; i++)
      words[i] = '0;
  end

  // write lands at the accepting edge
  always @(posedge clk)
  begin
    if (state == memIdle && req.we)
      words[wordAddr] <= req.wdata;
  end

  // read port registered every cycle from the held address
  always_ff @(posedge clk)
  begin
    rdata <= words[wordAddr];
  end

endmodule

// ==== cache/cacheArray.sv ====
`include "cache_settings.svh"

module cacheArray (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [31:0]                     addr,
  input  logic                            fillEn,
  input  logic [$clog2(`BLOCK_WORDS)-1:0] fillWord,
  input  logic [31:0]                     fillData,
  input  logic                            fillLast,
  input  logic                            updEn,
  input  logic [31:0]                     updData,
  output logic                            hit,
  output logic [31:0]                     rdWord
);

  localparam int offBits = $clog2(`BLOCK_WORDS);
  localparam int idxBits = $clog2(`CACHE_LINES);
  localparam int tagBits = 32 - 2 - offBits - idxBits;

  // address fields: tag | index | word offset | byte
  logic [offBits-1:0] offset;
  logic [idxBits-1:0] index;
  logic [tagBits-1:0] tag;

  // per-line storage
  logic [`CACHE_LINES-1:0] lineValid;
  logic [tagBits-1:0] tags [`CACHE_LINES];
  logic [31:0] data [`CACHE_LINES][`BLOCK_WORDS];

  assign offset = addr[offBits+1:2];
  assign index  = addr[offBits+idxBits+1:offBits+2];
  assign tag    = addr[31:offBits+idxBits+2];

  // lookup, purely combinational from the incoming address
  assign hit    = lineValid[index] && (tags[index] == tag);
  assign rdWord = data[index][offset];

  // valid bits, cleared by reset
  // a line turns valid with the last word of its fill
  always_ff @(posedge clk)
  begin
    if (rst)
      lineValid <= '0;
    else if (fillEn && fillLast)
      lineValid[index] <= 1'b1;
  end

  // tag and data arrays
  always_ff @(posedge clk)
  begin
    // fill writes one word of the block per memory access
    if (fillEn)
      data[index][fillWord] <= fillData;
    // tag goes in together with the final word
    if (fillEn && fillLast)
      tags[index] <= tag;
    // write hit keeps the cached copy in step with memory
    if (updEn)
      data[index][offset] <= updData;
  end

endmodule

// ==== cache/cacheController.sv ====
`include "cache_settings.svh"

module cacheController (
  input  logic                            clk,
  input  logic                            rst,
  input  cachePkg::cpuReq                 cpu,
  input  logic                            hit,
  input  logic                            memValid,
  input  logic [31:0]                     memData,
  output cachePkg::memReq                 mem,
  output logic                            fillEn,
  output logic                            fillLast,
  output logic                            updEn,
  output logic [$clog2(`BLOCK_WORDS)-1:0] fillWord,
  output logic                            stall
);
  import cachePkg::*;

  localparam int offBits = $clog2(`BLOCK_WORDS);
  localparam logic [offBits-1:0] lastWord = offBits'(`BLOCK_WORDS - 1);

  ctrlState state;
  ctrlState nextState;
  logic [offBits-1:0] wordCnt;
  logic lastFill;

  // final word of the block has come back
  assign lastFill = (state == ctrlFill) && memValid && (wordCnt == lastWord);

  // state register
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ctrlIdle;
    else
      state <= nextState;
  end

  // next state
  always_comb
  begin
    nextState = state;
    case (state)
      ctrlIdle:
        if (cpu.we)
          nextState = ctrlWrite;
        else if (cpu.re && !hit)
          nextState = ctrlFill;
      ctrlFill:
        if (lastFill)
          nextState = ctrlIdle;
      ctrlWrite:
        if (memValid)
          nextState = ctrlIdle;
      default:
        nextState = ctrlIdle;
    endcase
  end

  // word counter over the block
  // starts at zero for every fill, steps on each answer
  always_ff @(posedge clk)
  begin
    if (rst || state != ctrlFill)
      wordCnt <= '0;
    else if (memValid)
      wordCnt <= wordCnt + 1'b1;
  end

  // memory request, stable while the cpu request is held
  always_comb
  begin
    mem = '0;
    case (state)
      ctrlFill:
      begin
        // block base from the cpu address, offset from the counter
        mem.re   = 1'b1;
        mem.addr = {cpu.addr[31:offBits+2], wordCnt, 2'b00};
      end
      ctrlWrite:
      begin
        // write-through of the cpu word, no allocation
        mem.we    = 1'b1;
        mem.addr  = cpu.addr;
        mem.wdata = cpu.wdata;
      end
      default:
        mem = '0;
    endcase
  end

  // array writes
  assign fillEn   = (state == ctrlFill) && memValid;
  assign fillWord = wordCnt;
  assign fillLast = lastFill;
  // update the cached word only when the line is present
  assign updEn    = (state == ctrlWrite) && memValid && hit;

  // stall
  // idle: any write, or a read that misses
  // fill: always, the read completes once back in idle with a hit
  // write: until the memory answer
  always_comb
  begin
    case (state)
      ctrlIdle:  stall = cpu.we || (cpu.re && !hit);
      ctrlFill:  stall = 1'b1;
      ctrlWrite: stall = !memValid;
      default:   stall = 1'b0;
    endcase
  end

endmodule

// ==== src/memSubsystem.sv ====
`include "cache_settings.svh"

module memSubsystem (
  input  logic            clk,
  input  logic            rst,
  input  cachePkg::cpuReq cpu,
  output logic [31:0]     rdata,
  output logic            stall
);
  import cachePkg::*;

  // controller to memory
  memReq memRq;
  logic [31:0] memData;
  logic memValid;

  // controller to array
  logic hit;
  logic fillEn;
  logic fillLast;
  logic updEn;
  logic [$clog2(`BLOCK_WORDS)-1:0] fillWord;

  cacheController ctrl_i (
    .clk      (clk),
    .rst      (rst),
    .cpu      (cpu),
    .hit      (hit),
    .memValid (memValid),
    .memData  (memData),
    .mem      (memRq),
    .fillEn   (fillEn),
    .fillLast (fillLast),
    .updEn    (updEn),
    .fillWord (fillWord),
    .stall    (stall)
  );

  // fills take the memory word, write hits the cpu word
  cacheArray array_i (
    .clk      (clk),
    .rst      (rst),
    .addr     (cpu.addr),
    .fillEn   (fillEn),
    .fillWord (fillWord),
    .fillData (memData),
    .fillLast (fillLast),
    .updEn    (updEn),
    .updData  (cpu.wdata),
    .hit      (hit),
    .rdWord   (rdata)
  );

  slowMemory #(
    .waitCycles (`MEM_WAIT)
  ) mem_i (
    .clk   (clk),
    .rst   (rst),
    .req   (memRq),
    .rdata (memData),
    .valid (memValid)
  );

endmodule

// ==== bench/memSubsystem_assert.sv ====
`include "cache_settings.svh"

module memSubsystem_assert (
  input logic            clk,
  input logic            rst,
  input cachePkg::cpuReq cpu,
  input logic [31:0]     rdata,
  input logic            stall,
  input logic            memValid
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int offBits = $clog2(`BLOCK_WORDS);
  localparam int idxBits = $clog2(`CACHE_LINES);
  localparam int tagBits = 32 - 2 - offBits - idxBits;
  localparam int wordBits = $clog2(`MEM_WORDS);
  // worst case for a read miss, the request cycle and then one block walked word by word
  // each word: request cycle, MEM_WAIT+2 cycles until valid, the valid cycle
  localparam int missBound = `BLOCK_WORDS * (`MEM_WAIT + 4) + 1;

  int failCount;
  int stallRun;

  // shadow of main memory, only completed writes change it
  logic [31:0] shadow [`MEM_WORDS];
  // which block each line should hold after the completed reads
  logic [`CACHE_LINES-1:0] lineFilled;
  logic [tagBits-1:0] lineTag [`CACHE_LINES];

  logic [wordBits-1:0] wordAddr;
  logic [idxBits-1:0] index;
  logic [tagBits-1:0] tag;
  logic blockPresent;
  logic [31:0] expected;

  assign wordAddr = cpu.addr[wordBits+1:2];
  assign index = cpu.addr[offBits+idxBits+1:offBits+2];
  assign tag = cpu.addr[31:offBits+idxBits+2];
  assign blockPresent = lineFilled[index] && (lineTag[index] == tag);
  assign expected = shadow[wordAddr];

  initial
  begin
    failCount = 0;
  end

  // write-through, so memory and shadow agree after each write
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `MEM_WORDS; i++)
        shadow[i] <= '0;
    end
    else if (cpu.we && !stall)
      shadow[wordAddr] <= cpu.wdata;
  end

  // a completed read leaves its block in the line
  // writes never allocate
  always_ff @(posedge clk)
  begin
    if (rst)
      lineFilled <= '0;
    else if (cpu.re && !stall)
    begin
      lineFilled[index] <= 1'b1;
      lineTag[index] <= tag;
    end
  end

  // length of the current stall, in cycles before this one
  always_ff @(posedge clk)
  begin
    if (rst || !stall)
      stallRun <= 0;
    else
      stallRun <= stallRun + 1;
  end

  idleQuiet: assert property (@(posedge clk) disable iff (rst)
    !cpu.re && !cpu.we |-> !stall && !memValid)
  else
  begin
    failCount = failCount + 1;
    $error("stall or memory valid is high while no request is present");
  end

  readData: assert property (@(posedge clk) disable iff (rst)
    cpu.re && !stall |-> rdata == expected)
  else
  begin
    failCount = failCount + 1;
    $error("mismatch rdata expected %h actual %h", $sampled(expected), $sampled(rdata));
  end

  hitNoStall: assert property (@(posedge clk) disable iff (rst)
    cpu.re && blockPresent |-> !stall)
  else
  begin
    failCount = failCount + 1;
    $error("read of a block already in the cache was stalled");
  end

  missMinimum: assert property (@(posedge clk) disable iff (rst)
    cpu.re && !stall && stallRun != 0 |-> stallRun >= `MEM_WAIT + 2)
  else
  begin
    failCount = failCount + 1;
    $error("read miss finished sooner than main memory can answer");
  end

  stallLimit: assert property (@(posedge clk) disable iff (rst)
    stall |-> stallRun < missBound)
  else
  begin
    failCount = failCount + 1;
    $error("stall stayed high longer than a full block fill");
  end

  writeDone: assert property (@(posedge clk) disable iff (rst)
    cpu.we && !stall |-> memValid)
  else
  begin
    failCount = failCount + 1;
    $error("write finished without an answer from main memory");
  end

  // guards the stimulus itself
  holdRequest: assert property (@(posedge clk) disable iff (rst)
    stall |=> $stable(cpu))
  else
  begin
    failCount = failCount + 1;
    $error("processor request changed while stall was high");
  end

endmodule

bind memSubsystem memSubsystem_assert check_i (
  .clk      (clk),
  .rst      (rst),
  .cpu      (cpu),
  .rdata    (rdata),
  .stall    (stall),
  .memValid (memValid)
);

// ==== bench/memSubsystemTb.sv ====
`include "cache_settings.svh"

module memSubsystemTb;
  timeunit 1ns;
  timeprecision 100ps;
  import cachePkg::*;

  localparam int numOps = 400;
  localparam int resetCycles = 10;
  // budget per access, a full block fill plus some slack
  localparam int opCycles = `BLOCK_WORDS * (`MEM_WAIT + 4) + 4;
  localparam int cycleLimit = numOps * opCycles + resetCycles;

  logic clk;
  logic rst;
  cpuReq cpu;
  logic [31:0] rdata;
  logic stall;

  logic [31:0] rngState;
  int cycles;
  int timeouts;

  memSubsystem dut_i (
    .clk   (clk),
    .rst   (rst),
    .cpu   (cpu),
    .rdata (rdata),
    .stall (stall)
  );

  // 8 ns period
  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic drawRandom(output logic [31:0] r);
    rngState = xorshift(rngState);
    r = rngState;
  endtask

  // three lines, two tags per line, any word of the block
  function automatic logic [31:0] pickAddr(input logic [31:0] r);
    int tagSel;
    int line;
    int word;
    tagSel = int'(r[1]);
    line = int'(r[3:2]) % 3;
    word = int'(r[9:4]) % `BLOCK_WORDS;
    return 32'(((tagSel * `CACHE_LINES + line) * `BLOCK_WORDS + word) * 4);
  endfunction

  // hold the request until a cycle with stall low has passed
  task automatic issueAndWait(input cpuReq req);
    logic done;
    cpu = req;
    done = 1'b0;
    while (!done)
    begin
      // stall settles well before mid cycle
      #2;
      done = !stall;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic reportCounts();
    $display("assertion errors %0d, timeouts %0d", dut_i.check_i.failCount, timeouts);
  endtask

  // hang guard
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycleLimit)
    begin
      timeouts = timeouts + 1;
      $display("run did not finish within %0d cycles", cycleLimit);
      reportCounts();
      $display("tests failed");
      $finish;
    end
  end

  initial
  begin
    cpuReq req;
    logic [31:0] r;
    logic [31:0] w;
    clk = 1'b0;
    rst = 1'b1;
    cpu = '0;
    rngState = 32'h79a;
    cycles = 0;
    timeouts = 0;
    repeat (resetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
    // a few quiet cycles straight after reset
    repeat (2) @(posedge clk);
    #1;
    for (int n = 0; n < numOps; n++)
    begin
      drawRandom(r);
      drawRandom(w);
      req = '0;
      req.addr = pickAddr(r);
      req.wdata = w;
      // quarter idle, quarter writes, half reads
      case (r[11:10])
        2'd0: req.re = 1'b0;
        2'd1: req.we = 1'b1;
        default: req.re = 1'b1;
      endcase
      issueAndWait(req);
    end
    cpu = '0;
    // let the last assertions evaluate
    repeat (4) @(posedge clk);
    reportCounts();
    if (dut_i.check_i.failCount == 0 && timeouts == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+common
common/cachePkg.sv
memory/slowMemory.sv
cache/cacheArray.sv
cache/cacheController.sv
src/memSubsystem.sv
bench/memSubsystem_assert.sv
bench/memSubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module memSubsystemTb -f list.f

out=$(./obj_dir/VmemSubsystemTb +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi
